// File: Makefile
# Verilator flow for the token exchange controller

VERILATOR ?= verilator
FILELIST  ?= token_exchange.f
TB_TOP    ?= tb_token_exchange
RTL_TOP   ?= token_exchange_top
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --assert

SIM_BIN = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) test/token_model.svh
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)

# Exit status of the simulation is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: src/freq_lut.sv
`timescale 1ns/100ps

module freq_lut (
    input  logic                        clock,
    input  logic                        reset,
    input  token_config_pkg::lut_cmd_t  lut_cmd,
    input  token_packet_pkg::token_t    tokens_next,
    output token_config_pkg::freq_t     lut_read,
    output token_config_pkg::freq_t     freq_target
);

    import token_config_pkg::*;
    import token_packet_pkg::*;

    freq_t     lut_mem [LUT_DEPTH];             // Token count to frequency code
    lut_addr_t cmd_addr;                        // Configuration port address
    lut_addr_t target_addr;                     // Lookup address for target
    logic      cmd_write;
    logic      cmd_read;

    // ----------------------------------------------------------------------
    // Command decode
    // ----------------------------------------------------------------------
    assign cmd_write = lut_cmd[CMD_WEN_BIT];
    assign cmd_read  = lut_cmd[CMD_REN_BIT];
    assign cmd_addr  = lut_cmd[CMD_ADDR_LSB +: LUT_ADDR_WIDTH];     // Top two bits dropped

    // Negative count maps to the lowest entry
    assign target_addr = tokens_next[TOKEN_WIDTH-1] ? '0 :
                         tokens_next[LUT_ADDR_WIDTH-1:0];

    // ----------------------------------------------------------------------
    // Table, read port and target register
    // ----------------------------------------------------------------------
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < LUT_DEPTH; i++) begin
                lut_mem[i] <= '0;
            end
            lut_read    <= '0;
            freq_target <= '0;
        end else begin
            if (cmd_write) begin
                lut_mem[cmd_addr] <= lut_cmd[CMD_VALUE_LSB +: FREQ_WIDTH];
            end
            lut_read    <= cmd_read ? lut_mem[cmd_addr] : '0;   // Old data on same-cycle write
            freq_target <= lut_mem[target_addr];
        end
    end

    // Read in the cycle after a write to the same entry sees the new value
    assert property (@(posedge clock) disable iff (!reset)
        $past(reset) && $past(cmd_write) && cmd_read && (cmd_addr == $past(cmd_addr)) |=>
            lut_read == $past(lut_cmd[CMD_VALUE_LSB +: FREQ_WIDTH], 2))
        else $error("lut_read misses the value written one cycle earlier");

endmodule

// File: src/refresh_timer.sv
`timescale 1ns/100ps

module refresh_timer #(
    parameter int TIMER_WIDTH = 12
) (
    input  logic                            clock,
    input  logic                            reset,
    input  token_config_pkg::refresh_rate_t refresh_rate,
    input  logic                            status_sent,
    output logic                            status_due
);

    import token_config_pkg::*;

    // Compare at the wider of the two widths
    localparam int CMP_WIDTH = (TIMER_WIDTH > RATE_WIDTH) ? TIMER_WIDTH : RATE_WIDTH;

    logic [TIMER_WIDTH-1:0] count;              // Half-rate cycle count
    logic                   tick;               // Phase, count steps when set
    logic                   count_full;         // Saturation point

    assign count_full = &count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (status_sent) begin         // Restart period
            count <= '0;
            tick  <= 1'b0;
        end else begin
            tick <= ~tick;
            if (tick && !count_full) count <= count + 1'b1;   // Hold at max
        end
    end

    assign status_due = CMP_WIDTH'(count) > CMP_WIDTH'(refresh_rate);

    // Only a sent status packet brings the count back to zero
    assert property (@(posedge clock) disable iff (!reset)
        (count != '0) && !status_sent |=> count != '0)
        else $error("refresh counter wrapped without a status packet");

endmodule

// File: src/status_scheduler_fsm.sv
`timescale 1ns/100ps

module status_scheduler_fsm #(
    parameter int NEIGHBOR_COUNT = 4
) (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            status_due,
    input  logic                            packet_in,
    input  logic                            packet_out_ready,
    input  logic                            enable,
    input  logic [NEIGHBOR_COUNT*token_config_pkg::NEIGHBOR_FIELD_WIDTH-1:0] neighbors_id,
    input  token_packet_pkg::packet_word_t  status_payload,
    output logic                            packet_out,
    output token_packet_pkg::packet_word_t  packet_out_val,
    output token_packet_pkg::tile_addr_t    packet_out_addr,
    output logic                            status_sent
);

    import token_config_pkg::*;

    localparam int IDX_WIDTH = (NEIGHBOR_COUNT > 1) ? $clog2(NEIGHBOR_COUNT) : 1;
    localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(NEIGHBOR_COUNT - 1);

    localparam logic STATE_IDLE    = 1'b0;      // Waiting for timer
    localparam logic STATE_PENDING = 1'b1;      // Status owed, waiting for NoC

    logic                 state;
    logic                 state_next;
    logic [IDX_WIDTH-1:0] neighbor_idx;         // Round-robin pointer
    logic                 send_ok;              // Free, ready and enabled cycle

    // Incoming packet has the port this cycle, so status holds off
    assign send_ok     = packet_out_ready && enable && !packet_in;
    assign packet_out  = (state == STATE_PENDING) && send_ok;
    assign status_sent = packet_out;            // Restarts the timer

    assign packet_out_val  = packet_out ? status_payload : '0;
    // Field 0 sits in the low bits of neighbors_id
    assign packet_out_addr = packet_out ?
        neighbors_id[neighbor_idx*NEIGHBOR_FIELD_WIDTH +: NEIGHBOR_FIELD_WIDTH] : '0;

    // ----------------------------------------------------------------------
    // Next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            STATE_IDLE: begin
                if (status_due) state_next = STATE_PENDING;
            end
            STATE_PENDING: begin
                if (send_ok) state_next = STATE_IDLE;   // Packet leaves this cycle
            end
            default: state_next = STATE_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state        <= STATE_IDLE;
            neighbor_idx <= '0;
        end else begin
            state <= state_next;
            if (packet_out) begin                       // Advance after each send
                neighbor_idx <= (neighbor_idx == LAST_IDX) ? '0 : neighbor_idx + 1'b1;
            end
        end
    end

    // Each send drops the FSM back to idle for at least one cycle
    assert property (@(posedge clock) disable iff (!reset)
        packet_out |=> !packet_out)
        else $error("status packets sent in back-to-back cycles");

endmodule

// File: src/token_config_pkg.sv
package token_config_pkg;

    // ----------------------------------------------------------------------
    // Configuration port widths
    // ----------------------------------------------------------------------
    localparam int LUT_DEPTH            = 64;               // Entries in freq table
    localparam int LUT_ADDR_WIDTH       = $clog2(LUT_DEPTH);
    localparam int FREQ_WIDTH           = 8;                // Frequency code to LDO
    localparam int MAX_TOKENS_WIDTH     = 6;                // Unsigned tile maximum
    localparam int RATE_WIDTH           = 12;               // Refresh period
    localparam int LUT_CMD_WIDTH        = 18;
    localparam int NEIGHBOR_FIELD_WIDTH = 5;                // One neighbor address

    // ----------------------------------------------------------------------
    // Table command word layout
    // ----------------------------------------------------------------------
    localparam int CMD_WEN_BIT   = 17;          // Write enable
    localparam int CMD_REN_BIT   = 16;          // Read request
    localparam int CMD_VALUE_LSB = 8;           // Value in 15:8
    localparam int CMD_ADDR_LSB  = 0;           // Address in 7:0, low six used

    typedef logic [LUT_ADDR_WIDTH-1:0] lut_addr_t;
    typedef logic [FREQ_WIDTH-1:0] freq_t;
    typedef logic [MAX_TOKENS_WIDTH-1:0] max_tokens_t;
    typedef logic [RATE_WIDTH-1:0] refresh_rate_t;
    typedef logic [LUT_CMD_WIDTH-1:0] lut_cmd_t;

endpackage

// File: src/token_exchange_top.sv
`timescale 1ns/100ps

module token_exchange_top #(
    parameter int TIMER_WIDTH    = 12,          // Refresh counter width
    parameter int NEIGHBOR_COUNT = 4            // W/E/N/S
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                packet_in,
    input  token_packet_pkg::packet_word_t      packet_in_val,
    input  logic                                packet_out_ready,
    input  logic                                enable,
    input  logic                                activity,
    input  token_config_pkg::max_tokens_t       max_tokens,
    input  logic [7:0]                          token_counter_override,
    input  token_config_pkg::refresh_rate_t     refresh_rate,
    input  logic [NEIGHBOR_COUNT*token_config_pkg::NEIGHBOR_FIELD_WIDTH-1:0] neighbors_id,
    input  token_config_pkg::lut_cmd_t          lut_cmd,
    output logic                                packet_out,
    output token_packet_pkg::packet_word_t      packet_out_val,
    output token_packet_pkg::tile_addr_t        packet_out_addr,
    output token_packet_pkg::token_t            tokens_next,
    output token_config_pkg::freq_t             lut_read,
    output token_config_pkg::freq_t             freq_target
);

    import token_packet_pkg::*;

    logic         status_due;                   // Timer to scheduler
    logic         status_sent;                  // Scheduler to timer, one cycle
    packet_word_t status_payload;               // Status view built by ledger

    // ----------------------------------------------------------------------
    // Status path
    // ----------------------------------------------------------------------
    refresh_timer #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) refresh_timer_inst (
        .clock        (clock),
        .reset        (reset),
        .refresh_rate (refresh_rate),
        .status_sent  (status_sent),
        .status_due   (status_due)
    );

    status_scheduler_fsm #(
        .NEIGHBOR_COUNT (NEIGHBOR_COUNT)
    ) status_scheduler_fsm_inst (
        .clock            (clock),
        .reset            (reset),
        .status_due       (status_due),
        .packet_in        (packet_in),
        .packet_out_ready (packet_out_ready),
        .enable           (enable),
        .neighbors_id     (neighbors_id),
        .status_payload   (status_payload),
        .packet_out       (packet_out),
        .packet_out_val   (packet_out_val),
        .packet_out_addr  (packet_out_addr),
        .status_sent      (status_sent)
    );

    // ----------------------------------------------------------------------
    // Token count and frequency
    // ----------------------------------------------------------------------
    token_ledger token_ledger_inst (
        .clock                  (clock),
        .reset                  (reset),
        .packet_in              (packet_in),
        .packet_in_val          (packet_in_val),
        .enable                 (enable),
        .activity               (activity),
        .max_tokens             (max_tokens),
        .token_counter_override (token_counter_override),
        .tokens_next            (tokens_next),
        .token_count            (),
        .status_payload         (status_payload)
    );

    freq_lut freq_lut_inst (
        .clock       (clock),
        .reset       (reset),
        .lut_cmd     (lut_cmd),
        .tokens_next (tokens_next),
        .lut_read    (lut_read),
        .freq_target (freq_target)
    );

endmodule

// File: src/token_ledger.sv
`timescale 1ns/100ps

module token_ledger (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            packet_in,
    input  token_packet_pkg::packet_word_t  packet_in_val,
    input  logic                            enable,
    input  logic                            activity,
    input  token_config_pkg::max_tokens_t   max_tokens,
    input  logic [7:0]                      token_counter_override,
    output token_packet_pkg::token_t        tokens_next,
    output token_packet_pkg::token_t        token_count,
    output token_packet_pkg::packet_word_t  status_payload
);

    import token_packet_pkg::*;
    import token_config_pkg::*;

    localparam int OVR_BIT = TOKEN_WIDTH;       // Override valid flag, bit 7

    logic        update_hit;                    // Accepted update packet
    token_t      delta;                         // Signed delta from update view
    max_tokens_t needs_act;                     // Needs gated by activity

    // Status packets fall through untouched
    assign update_hit = packet_in && enable &&
                        (packet_in_val.update[TYPE_BIT] == PKT_UPDATE);
    assign delta      = packet_in_val.update[DELTA_LSB +: TOKEN_WIDTH];

    // ----------------------------------------------------------------------
    // Counter update
    // ----------------------------------------------------------------------
    always_comb begin
        tokens_next = token_count;
        if (update_hit) begin
            tokens_next = token_count + delta;  // Wraps in 7 bits
        end
        if (token_counter_override[OVR_BIT]) begin   // Software wins
            tokens_next = token_counter_override[TOKEN_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) token_count <= '0;
        else token_count <= tokens_next;
    end

    // ----------------------------------------------------------------------
    // Status payload, sent by the scheduler
    // ----------------------------------------------------------------------
    assign needs_act = activity ? max_tokens : '0;  // Idle tile needs nothing

    always_comb begin
        status_payload = '0;
        status_payload.status[TYPE_BIT]                  = PKT_STATUS;
        status_payload.status[NEEDS_LSB +: NEEDS_WIDTH]  = NEEDS_WIDTH'(needs_act);
        status_payload.status[HAS_LSB +: TOKEN_WIDTH]    = token_count;
    end

    assert property (@(posedge clock) disable iff (!reset)
        token_counter_override[OVR_BIT] |=>
            token_count == $past(token_counter_override[TOKEN_WIDTH-1:0]))
        else $error("override value not loaded into token counter");

endmodule

// File: src/token_packet_pkg.sv
package token_packet_pkg;

    // ----------------------------------------------------------------------
    // Packet field widths
    // ----------------------------------------------------------------------
    localparam int PACKET_WIDTH = 32;           // One NoC flit payload
    localparam int TOKEN_WIDTH  = 7;            // Signed token count
    localparam int ADDR_WIDTH   = 5;            // 32 tiles addressable
    localparam int NEEDS_WIDTH  = 10;           // Status needs field

    // ----------------------------------------------------------------------
    // Bit positions inside the packet word
    // ----------------------------------------------------------------------
    localparam int TYPE_BIT  = 31;              // Packet type flag
    localparam int NEEDS_LSB = 10;              // Needs in 19:10
    localparam int HAS_LSB   = 0;               // Has in 6:0
    localparam int DELTA_LSB = 0;               // Signed delta in 6:0

    // Type bit values
    localparam logic PKT_STATUS = 1'b1;
    localparam logic PKT_UPDATE = 1'b0;

    typedef logic signed [TOKEN_WIDTH-1:0] token_t;    // Two's complement count
    typedef logic [ADDR_WIDTH-1:0] tile_addr_t;

    // Same 32-bit word, decoded by the type bit
    // Bits not named above stay zero in both views
    typedef union packed {
        logic [PACKET_WIDTH-1:0] status;        // Type, needs, has
        logic [PACKET_WIDTH-1:0] update;        // Type, delta
    } packet_word_t;

endpackage

// File: test/token_model.svh
`ifndef TOKEN_MODEL_SVH
`define TOKEN_MODEL_SVH

// ----------------------------------------------------------------------
// Reference model state, as of the last rising edge
// ----------------------------------------------------------------------
token_t model_count;                            // Registered token count
freq_t  model_lut [64];                         // Copy of the frequency table
freq_t  model_lut_read;                         // Expected read port
freq_t  model_target;                           // Expected freq_target
int     model_neighbor;                         // Round-robin position
int     last_status_cycle;                      // -1 until the first status packet

task automatic reset_model();
    model_count       = '0;
    model_lut_read    = '0;
    model_target      = '0;
    model_neighbor    = 0;
    last_status_cycle = -1;
    for (int i = 0; i < 64; i++) begin
        model_lut[i] = '0;
    end
endtask

// Counter value after this cycle's inputs
function automatic token_t predict_tokens(logic pkt_in, packet_word_t pkt, logic en,
                                          logic [7:0] ovr);
    token_t nxt;
    nxt = model_count;
    if (pkt_in && en && (pkt.update[31] == 1'b0)) begin     // Update packets only
        nxt = model_count + token_t'(pkt.update[6:0]);      // 7-bit wrap
    end
    if (ovr[7]) begin                                       // Software override wins
        nxt = token_t'(ovr[6:0]);
    end
    return nxt;
endfunction

// Negative counts fall back to entry 0
function automatic lut_addr_t lut_index(token_t tokens);
    return tokens[6] ? 6'd0 : tokens[5:0];
endfunction

function automatic packet_word_t expected_status_word(logic act, max_tokens_t mt);
    packet_word_t w;
    w = '0;
    w.status[31]    = 1'b1;                     // Status type
    w.status[19:10] = act ? {4'd0, mt} : 10'd0; // Idle tile asks for nothing
    w.status[6:0]   = model_count;
    return w;
endfunction

function automatic tile_addr_t expected_neighbor(neighbor_list_t ids);
    return ids[model_neighbor*5 +: 5];          // Field 0 in the low bits
endfunction

// One clock edge of the counter and table
task automatic advance_model(lut_cmd_t cmd, token_t nxt);
    lut_addr_t a;
    a = cmd[5:0];                               // Bits 7:6 ignored
    model_lut_read = cmd[16] ? model_lut[a] : '0;   // Read sees old data
    model_target   = model_lut[lut_index(nxt)];
    if (cmd[17]) begin
        model_lut[a] = cmd[15:8];
    end
    model_count = nxt;
endtask

task automatic note_status_sent(int at_cycle);
    model_neighbor    = (model_neighbor + 1) % NEIGHBORS;
    last_status_cycle = at_cycle;
endtask

`endif

// File: test/tb_token_exchange.sv
`timescale 1ns/100ps

module tb_token_exchange;

    import token_packet_pkg::*;
    import token_config_pkg::*;

    localparam int NEIGHBORS      = 4;
    localparam int RANDOM_CYCLES  = 3000;
    localparam int STATUS_TIMEOUT = 200;        // Cycles, well above the slowest period

    typedef logic [NEIGHBORS*NEIGHBOR_FIELD_WIDTH-1:0] neighbor_list_t;

    logic           clock;
    logic           reset;
    logic           packet_in;
    packet_word_t   packet_in_val;
    logic           packet_out_ready;
    logic           enable;
    logic           activity;
    max_tokens_t    max_tokens;
    logic [7:0]     token_counter_override;
    refresh_rate_t  refresh_rate;
    neighbor_list_t neighbors_id;
    lut_cmd_t       lut_cmd;
    logic           packet_out;
    packet_word_t   packet_out_val;
    tile_addr_t     packet_out_addr;
    token_t         tokens_next;
    freq_t          lut_read;
    freq_t          freq_target;

    int   cycle;                                // Sampled cycles since reset
    int   status_count;                         // Status packets seen
    logic rate_change_due;                      // New period after each packet

    `include "token_model.svh"

    token_exchange_top #(
        .TIMER_WIDTH    (12),
        .NEIGHBOR_COUNT (NEIGHBORS)
    ) token_exchange_top_inst (
        .clock                  (clock),
        .reset                  (reset),
        .packet_in              (packet_in),
        .packet_in_val          (packet_in_val),
        .packet_out_ready       (packet_out_ready),
        .enable                 (enable),
        .activity               (activity),
        .max_tokens             (max_tokens),
        .token_counter_override (token_counter_override),
        .refresh_rate           (refresh_rate),
        .neighbors_id           (neighbors_id),
        .lut_cmd                (lut_cmd),
        .packet_out             (packet_out),
        .packet_out_val         (packet_out_val),
        .packet_out_addr        (packet_out_addr),
        .tokens_next            (tokens_next),
        .lut_read               (lut_read),
        .freq_target            (freq_target)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;             // 40 ns period
    end

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic check_token(string name, token_t got, token_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_freq(string name, freq_t got, freq_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_word(string name, packet_word_t got, packet_word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    task automatic check_addr(string name, tile_addr_t got, tile_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s: expected %0d, got %0d", $time, name, exp, got);
            stop_with_failure();
        end
    endtask

    // ----------------------------------------------------------------------
    // Sampling at the falling edge, where all outputs have settled
    // ----------------------------------------------------------------------
    task automatic check_status_packet();
        if (!packet_out_ready || !enable || packet_in) begin
            $display("%0t: status packet sent while the network was not ready,", $time);
            $display("enable was low or an incoming packet held the port");
            stop_with_failure();
        end
        check_word("packet_out_val", packet_out_val, expected_status_word(activity, max_tokens));
        check_addr("packet_out_addr", packet_out_addr, expected_neighbor(neighbors_id));
        if (last_status_cycle >= 0 &&
            cycle - last_status_cycle < int'(refresh_rate) + 2) begin
            $display("%0t: status packets only %0d cycles apart with refresh_rate %0d",
                     $time, cycle - last_status_cycle, refresh_rate);
            stop_with_failure();
        end
        note_status_sent(cycle);
        status_count++;
        rate_change_due = 1'b1;
    endtask

    task automatic sample_cycle();
        token_t exp_next;
        @(negedge clock);
        exp_next = predict_tokens(packet_in, packet_in_val, enable, token_counter_override);
        check_token("tokens_next", tokens_next, exp_next);
        check_freq("lut_read", lut_read, model_lut_read);
        check_freq("freq_target", freq_target, model_target);
        if (packet_out) begin
            check_status_packet();
        end
        advance_model(lut_cmd, exp_next);
        cycle++;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus, called right after a rising edge
    // ----------------------------------------------------------------------
    task automatic apply_rate_change();
        if (rate_change_due) begin              // Timer has just restarted
            refresh_rate    <= refresh_rate_t'(2 + $urandom % 19);
            rate_change_due = 1'b0;
        end
    endtask

    task automatic drive_fill(int idx);
        packet_in              <= 1'b0;
        packet_out_ready       <= 1'b0;         // Status stays owed meanwhile
        enable                 <= 1'b1;
        token_counter_override <= 8'h00;
        lut_cmd                <= {1'b1, 1'b0, freq_t'((idx * 37 + 11) ^ (idx >> 3)), 2'b00,
                                   6'(idx)};
        apply_rate_change();
    endtask

    task automatic drive_random();
        packet_word_t word;
        logic         wen;
        logic         ren;
        if ($urandom % 5 == 0) begin            // Status packet, to be ignored
            word.status = {1'b1, 11'd0, 10'($urandom), 3'd0, 7'($urandom)};
        end else begin
            word.update = {1'b0, 24'd0, 7'($urandom)};
        end
        wen = ($urandom % 10) < 3;
        ren = ($urandom % 10) < 4;
        packet_in              <= ($urandom % 100) < 40;
        packet_in_val          <= word;
        enable                 <= ($urandom % 100) < 85;
        activity               <= 1'($urandom);
        max_tokens             <= max_tokens_t'($urandom);
        token_counter_override <= {(($urandom % 100) < 8), 7'($urandom)};
        lut_cmd                <= {wen, ren, freq_t'($urandom), 8'($urandom)};
        if ($urandom % 4 == 0) begin
            packet_out_ready <= !packet_out_ready;
        end
        apply_rate_change();
    endtask

    task automatic drive_drain();
        packet_in              <= 1'b0;
        packet_out_ready       <= 1'b1;
        enable                 <= 1'b1;
        activity               <= 1'($urandom);
        token_counter_override <= 8'h00;
        lut_cmd                <= '0;
        apply_rate_change();
    endtask

    task automatic wait_for_status();
        int start;
        int waited;
        start  = status_count;
        waited = 0;
        while (status_count == start && waited < STATUS_TIMEOUT) begin
            sample_cycle();
            @(posedge clock);
            drive_drain();
            waited++;
        end
        if (status_count == start) begin
            $display("%0t: no status packet within %0d cycles with packet_out_ready held high",
                     $time, STATUS_TIMEOUT);
            stop_with_failure();
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int sent_before;
        void'($urandom(591));
        reset                  <= 1'b0;
        packet_in              <= 1'b0;
        packet_in_val          <= '0;
        packet_out_ready       <= 1'b0;
        enable                 <= 1'b0;
        activity               <= 1'b0;
        max_tokens             <= '0;
        token_counter_override <= 8'h00;
        refresh_rate           <= refresh_rate_t'(8);
        neighbors_id           <= neighbor_list_t'($urandom);
        lut_cmd                <= '0;
        cycle           = 0;
        status_count    = 0;
        rate_change_due = 1'b0;
        reset_model();
        repeat (3) @(posedge clock);
        reset <= 1'b1;

        for (int i = 0; i < LUT_DEPTH; i++) begin   // Load every table entry
            sample_cycle();
            @(posedge clock);
            drive_fill(i);
        end

        sent_before = status_count;
        repeat (RANDOM_CYCLES) begin
            sample_cycle();
            @(posedge clock);
            drive_random();
        end
        if (status_count == sent_before) begin
            $display("%0t: no status packet was sent during random traffic", $time);
            stop_with_failure();
        end

        repeat (NEIGHBORS + 1) wait_for_status();  // Full rotation plus a wrap
        sample_cycle();

        $display("No errors");
        $finish;
    end

endmodule

// File: token_exchange.f
+incdir+test
src/token_packet_pkg.sv
src/token_config_pkg.sv
src/refresh_timer.sv
src/status_scheduler_fsm.sv
src/token_ledger.sv
src/freq_lut.sv
src/token_exchange_top.sv
test/tb_token_exchange.sv
